/* files.f */
+incdir+logic
logic/pipe_pkg.sv
logic/bubble_pkg.sv
logic/sb_query_if.sv
logic/scoreboard_tracker.sv
logic/exe_bubble_classifier.sv
logic/bubble_counter_bank.sv
logic/bubble_profiler_top.sv
tests/bubble_profiler_sva.sv
tests/bubble_profiler_tb.sv

/* logic/bubble_consts.svh */
`ifndef BUBBLE_CONSTS_SVH
`define BUBBLE_CONSTS_SVH

// pipeline widths
`define BP_PC_WIDTH       32
`define BP_REG_ADDR_WIDTH 5
`define BP_REG_ELS        32

// profiling counters
`define BP_CNT_WIDTH      16 // saturates at all ones
`define BP_EXE_CLASSES    14 // one per exe_bubble_e value

`endif

/* logic/bubble_counter_bank.sv */
`default_nettype none
`include "bubble_consts.svh"

module bubble_counter_bank (
  input  wire                          clk_i,
  input  wire                          reset_i,
  input  wire                          stall_all_i,
  input  wire bubble_pkg::exe_bubble_e bubble_i,

  // readout request
  input  wire                          cnt_req_valid_i,
  input  wire bubble_pkg::exe_bubble_e cnt_req_class_i,
  output logic                         cnt_req_ready_o,

  // readout response
  output logic                         cnt_resp_valid_o,
  output logic [`BP_CNT_WIDTH-1:0]     cnt_resp_count_o,
  input  wire                          cnt_resp_ready_i
);

  logic [`BP_CNT_WIDTH-1:0] cnt_r [`BP_EXE_CLASSES-1:0];
  logic [`BP_CNT_WIDTH-1:0] req_count;
  logic [`BP_CNT_WIDTH-1:0] resp_count_r;
  logic                     resp_valid_r;
  logic                     req_fire;

  assign cnt_req_ready_o = ~resp_valid_r; // single response slot
  assign req_fire        = cnt_req_valid_i & cnt_req_ready_o;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      for (int i = 0; i < `BP_EXE_CLASSES; i++) begin
        cnt_r[i] <= '0;
      end
    end else if (!stall_all_i) begin
      for (int i = 0; i < `BP_EXE_CLASSES; i++) begin
        if (int'(bubble_i) == i && cnt_r[i] != '1) begin
          cnt_r[i] <= cnt_r[i] + 1'b1; // saturating
        end
      end
    end
  end

  always_comb begin
    req_count = '0;
    for (int i = 0; i < `BP_EXE_CLASSES; i++) begin
      if (int'(cnt_req_class_i) == i) begin
        req_count = cnt_r[i];
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      resp_valid_r <= 1'b0;
    end else if (req_fire) begin
      resp_valid_r <= 1'b1;
    end else if (cnt_resp_ready_i) begin
      resp_valid_r <= 1'b0;
    end
  end

  // snapshot at accept, counting goes on behind it
  always_ff @(posedge clk_i) begin
    if (req_fire) begin
      resp_count_r <= req_count;
    end
  end

  assign cnt_resp_valid_o = resp_valid_r;
  assign cnt_resp_count_o = resp_count_r;

endmodule

`default_nettype wire

/* logic/bubble_pkg.sv */
`default_nettype none

package bubble_pkg;

  // two-stage classes park here for one cycle before EXE
  typedef enum logic [1:0] {
    e_id_branch_miss,
    e_id_jalr_miss,
    e_id_icache_miss,
    e_id_no_bubble
  } id_bubble_e;

  // also the counter index
  typedef enum logic [3:0] {
    e_exe_no_bubble = 4'd0,
    e_exe_branch_miss,
    e_exe_jalr_miss,
    e_exe_icache_miss,
    e_exe_depend_dram,
    e_exe_depend_group,
    e_exe_depend_global,
    e_exe_depend_idiv,
    e_exe_depend_local_load,
    e_exe_depend_imul,
    e_exe_bypass,
    e_exe_remote_req,
    e_exe_remote_credit,
    e_exe_idiv_busy
  } exe_bubble_e;

endpackage

`default_nettype wire

/* logic/bubble_profiler_top.sv */
`default_nettype none
`include "bubble_consts.svh"

module bubble_profiler_top (
  input  wire                          clk_i,
  input  wire                          reset_i,

  input  wire                          issue_i,
  input  wire pipe_pkg::long_op_e      issue_kind_i,
  input  wire pipe_pkg::reg_addr_t     issue_rd_i,
  input  wire                          clear_i,
  input  wire pipe_pkg::reg_addr_t     clear_rd_i,

  input  wire [`BP_PC_WIDTH-1:0]       if_pc_i,
  input  wire [`BP_PC_WIDTH-1:0]       id_pc_i,
  input  wire [`BP_PC_WIDTH-1:0]       exe_pc_i,
  input  wire pipe_pkg::id_instr_s     id_instr_i,

  input  wire                          stall_all_i,
  input  wire                          icache_miss_i,
  input  wire                          icache_miss_in_pipe_i,
  input  wire                          branch_mispredict_i,
  input  wire                          jalr_mispredict_i,
  input  wire                          stall_depend_long_op_i,
  input  wire                          stall_depend_local_load_i,
  input  wire                          stall_depend_imul_i,
  input  wire                          stall_bypass_i,
  input  wire                          stall_remote_req_i,
  input  wire                          stall_remote_credit_i,
  input  wire                          stall_idiv_busy_i,

  output bubble_pkg::exe_bubble_e      exe_bubble_type_o,
  output logic [`BP_PC_WIDTH-1:0]      exe_bubble_pc_o,

  input  wire                          cnt_req_valid_i,
  input  wire bubble_pkg::exe_bubble_e cnt_req_class_i,
  output logic                         cnt_req_ready_o,
  output logic                         cnt_resp_valid_o,
  output logic [`BP_CNT_WIDTH-1:0]     cnt_resp_count_o,
  input  wire                          cnt_resp_ready_i
);

  bubble_pkg::exe_bubble_e exe_bubble; // feeds the counters too

  exe_bubble_classifier classifier (
    .clk_i                     (clk_i),
    .reset_i                   (reset_i),
    .if_pc_i                   (if_pc_i),
    .id_pc_i                   (id_pc_i),
    .exe_pc_i                  (exe_pc_i),
    .id_instr_i                (id_instr_i),
    .issue_i                   (issue_i),
    .issue_kind_i              (issue_kind_i),
    .issue_rd_i                (issue_rd_i),
    .clear_i                   (clear_i),
    .clear_rd_i                (clear_rd_i),
    .stall_all_i               (stall_all_i),
    .icache_miss_i             (icache_miss_i),
    .icache_miss_in_pipe_i     (icache_miss_in_pipe_i),
    .branch_mispredict_i       (branch_mispredict_i),
    .jalr_mispredict_i         (jalr_mispredict_i),
    .stall_depend_long_op_i    (stall_depend_long_op_i),
    .stall_depend_local_load_i (stall_depend_local_load_i),
    .stall_depend_imul_i       (stall_depend_imul_i),
    .stall_bypass_i            (stall_bypass_i),
    .stall_remote_req_i        (stall_remote_req_i),
    .stall_remote_credit_i     (stall_remote_credit_i),
    .stall_idiv_busy_i         (stall_idiv_busy_i),
    .exe_bubble_type_o         (exe_bubble),
    .exe_bubble_pc_o           (exe_bubble_pc_o)
  );

  bubble_counter_bank counters (
    .clk_i            (clk_i),
    .reset_i          (reset_i),
    .stall_all_i      (stall_all_i),
    .bubble_i         (exe_bubble),
    .cnt_req_valid_i  (cnt_req_valid_i),
    .cnt_req_class_i  (cnt_req_class_i),
    .cnt_req_ready_o  (cnt_req_ready_o),
    .cnt_resp_valid_o (cnt_resp_valid_o),
    .cnt_resp_count_o (cnt_resp_count_o),
    .cnt_resp_ready_i (cnt_resp_ready_i)
  );

  assign exe_bubble_type_o = exe_bubble;

endmodule

`default_nettype wire

/* logic/exe_bubble_classifier.sv */
`default_nettype none
`include "bubble_consts.svh"

module exe_bubble_classifier (
  input  wire                           clk_i,
  input  wire                           reset_i,

  input  wire [`BP_PC_WIDTH-1:0]        if_pc_i,
  input  wire [`BP_PC_WIDTH-1:0]        id_pc_i,
  input  wire [`BP_PC_WIDTH-1:0]        exe_pc_i,
  input  wire pipe_pkg::id_instr_s      id_instr_i,

  // scoreboard updates
  input  wire                           issue_i,
  input  wire pipe_pkg::long_op_e       issue_kind_i,
  input  wire pipe_pkg::reg_addr_t      issue_rd_i,
  input  wire                           clear_i,
  input  wire pipe_pkg::reg_addr_t      clear_rd_i,

  input  wire                           stall_all_i,
  input  wire                           icache_miss_i,
  input  wire                           icache_miss_in_pipe_i,
  input  wire                           branch_mispredict_i,
  input  wire                           jalr_mispredict_i,
  input  wire                           stall_depend_long_op_i,
  input  wire                           stall_depend_local_load_i,
  input  wire                           stall_depend_imul_i,
  input  wire                           stall_bypass_i,
  input  wire                           stall_remote_req_i,
  input  wire                           stall_remote_credit_i,
  input  wire                           stall_idiv_busy_i,

  output bubble_pkg::exe_bubble_e       exe_bubble_type_o,
  output logic [`BP_PC_WIDTH-1:0]       exe_bubble_pc_o
);

  logic [`BP_PC_WIDTH-1:0] icache_miss_pc_r;
  bubble_pkg::id_bubble_e  id_bubble_r;
  logic [`BP_PC_WIDTH-1:0] id_bubble_pc_r;
  bubble_pkg::exe_bubble_e exe_bubble_r, exe_bubble_n;
  logic [`BP_PC_WIDTH-1:0] exe_bubble_pc_r, exe_bubble_pc_n;
  logic dep_dram, dep_group, dep_global, dep_idiv;

  sb_query_if sb_q ();

  scoreboard_tracker sb_tracker (
    .clk_i        (clk_i),
    .reset_i      (reset_i),
    .issue_i      (issue_i),
    .issue_kind_i (issue_kind_i),
    .issue_rd_i   (issue_rd_i),
    .clear_i      (clear_i),
    .clear_rd_i   (clear_rd_i),
    .sb           (sb_q)
  );

  assign sb_q.id_instr = id_instr_i;

  function automatic logic any_owned(
    input pipe_pkg::long_op_e kind,
    input pipe_pkg::long_op_e a,
    input pipe_pkg::long_op_e b,
    input pipe_pkg::long_op_e c
  );
    return (a == kind) | (b == kind) | (c == kind);
  endfunction

  assign dep_dram   = stall_depend_long_op_i
                    & any_owned(pipe_pkg::e_op_dram_load, sb_q.rs1_kind, sb_q.rs2_kind,
                                sb_q.rd_kind);
  assign dep_group  = stall_depend_long_op_i
                    & any_owned(pipe_pkg::e_op_group_load, sb_q.rs1_kind, sb_q.rs2_kind,
                                sb_q.rd_kind);
  assign dep_global = stall_depend_long_op_i
                    & any_owned(pipe_pkg::e_op_global_load, sb_q.rs1_kind, sb_q.rs2_kind,
                                sb_q.rd_kind);
  assign dep_idiv   = stall_depend_long_op_i
                    & any_owned(pipe_pkg::e_op_idiv, sb_q.rs1_kind, sb_q.rs2_kind,
                                sb_q.rd_kind);

  // fetch pc of the last miss, consumed when the miss reaches ID
  always_ff @(posedge clk_i) begin
    if (icache_miss_i && !stall_all_i) begin
      icache_miss_pc_r <= if_pc_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      id_bubble_r    <= bubble_pkg::e_id_no_bubble;
      id_bubble_pc_r <= '0;
    end else if (!stall_all_i) begin
      if (branch_mispredict_i) begin
        id_bubble_r    <= bubble_pkg::e_id_branch_miss;
        id_bubble_pc_r <= exe_pc_i;
      end else if (jalr_mispredict_i) begin
        id_bubble_r    <= bubble_pkg::e_id_jalr_miss;
        id_bubble_pc_r <= exe_pc_i;
      end else if (icache_miss_in_pipe_i) begin
        id_bubble_r    <= bubble_pkg::e_id_icache_miss;
        id_bubble_pc_r <= icache_miss_pc_r;
      end else begin
        id_bubble_r    <= bubble_pkg::e_id_no_bubble;
        id_bubble_pc_r <= '0;
      end
    end
  end

  // fixed priority, highest first
  always_comb begin
    exe_bubble_n    = bubble_pkg::e_exe_no_bubble;
    exe_bubble_pc_n = id_pc_i; // stall causes blame ID
    if (branch_mispredict_i) begin
      exe_bubble_n    = bubble_pkg::e_exe_branch_miss;
      exe_bubble_pc_n = exe_pc_i;
    end else if (jalr_mispredict_i) begin
      exe_bubble_n    = bubble_pkg::e_exe_jalr_miss;
      exe_bubble_pc_n = exe_pc_i;
    end else if (id_bubble_r != bubble_pkg::e_id_no_bubble) begin
      exe_bubble_pc_n = id_bubble_pc_r;
      case (id_bubble_r)
        bubble_pkg::e_id_branch_miss: exe_bubble_n = bubble_pkg::e_exe_branch_miss;
        bubble_pkg::e_id_jalr_miss:   exe_bubble_n = bubble_pkg::e_exe_jalr_miss;
        default:                      exe_bubble_n = bubble_pkg::e_exe_icache_miss;
      endcase
    end else if (dep_dram) exe_bubble_n = bubble_pkg::e_exe_depend_dram;
    else if (dep_group) exe_bubble_n = bubble_pkg::e_exe_depend_group;
    else if (dep_global) exe_bubble_n = bubble_pkg::e_exe_depend_global;
    else if (dep_idiv) exe_bubble_n = bubble_pkg::e_exe_depend_idiv;
    else if (stall_depend_local_load_i) exe_bubble_n = bubble_pkg::e_exe_depend_local_load;
    else if (stall_depend_imul_i) exe_bubble_n = bubble_pkg::e_exe_depend_imul;
    else if (stall_bypass_i) exe_bubble_n = bubble_pkg::e_exe_bypass;
    else if (stall_remote_req_i) exe_bubble_n = bubble_pkg::e_exe_remote_req;
    else if (stall_remote_credit_i) exe_bubble_n = bubble_pkg::e_exe_remote_credit;
    else if (stall_idiv_busy_i) exe_bubble_n = bubble_pkg::e_exe_idiv_busy;
    else exe_bubble_pc_n = '0; // no cause
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      exe_bubble_r    <= bubble_pkg::e_exe_no_bubble;
      exe_bubble_pc_r <= '0;
    end else if (!stall_all_i) begin
      exe_bubble_r    <= exe_bubble_n;
      exe_bubble_pc_r <= exe_bubble_pc_n;
    end
  end

  assign exe_bubble_type_o = exe_bubble_r;
  assign exe_bubble_pc_o   = exe_bubble_pc_r;

endmodule

`default_nettype wire

/* logic/pipe_pkg.sv */
`default_nettype none
`include "bubble_consts.svh"

package pipe_pkg;

  typedef logic [`BP_REG_ADDR_WIDTH-1:0] reg_addr_t;

  // owner of a pending integer destination
  typedef enum logic [2:0] {
    e_op_none,
    e_op_dram_load,
    e_op_group_load,
    e_op_global_load,
    e_op_idiv
  } long_op_e;

  // decoded fields of the instruction sitting in ID
  typedef struct packed {
    reg_addr_t rs1;
    reg_addr_t rs2;
    reg_addr_t rd;
    logic      read_rs1;
    logic      read_rs2;
    logic      write_rd;
  } id_instr_s;

endpackage

`default_nettype wire

/* logic/sb_query_if.sv */
`default_nettype none

// combinational dependency lookup, no handshake
interface sb_query_if;

  pipe_pkg::id_instr_s id_instr;

  // e_op_none when the matching decode flag is clear
  pipe_pkg::long_op_e  rs1_kind;
  pipe_pkg::long_op_e  rs2_kind;
  pipe_pkg::long_op_e  rd_kind;

  modport classifier (
    output id_instr,
    input  rs1_kind, rs2_kind, rd_kind
  );

  modport tracker (
    input  id_instr,
    output rs1_kind, rs2_kind, rd_kind
  );

endinterface

`default_nettype wire

/* logic/scoreboard_tracker.sv */
`default_nettype none
`include "bubble_consts.svh"

module scoreboard_tracker (
  input  wire                      clk_i,
  input  wire                      reset_i,

  // long op leaving ID
  input  wire                      issue_i,
  input  wire pipe_pkg::long_op_e  issue_kind_i,
  input  wire pipe_pkg::reg_addr_t issue_rd_i,

  // writeback
  input  wire                      clear_i,
  input  wire pipe_pkg::reg_addr_t clear_rd_i,

  sb_query_if.tracker              sb
);

  pipe_pkg::long_op_e sb_r [`BP_REG_ELS-1:0];
  pipe_pkg::long_op_e sb_n [`BP_REG_ELS-1:0];

  // issue is applied last so it wins over a clear to the same rd
  always_comb begin
    sb_n = sb_r;
    if (clear_i) begin
      sb_n[clear_rd_i] = pipe_pkg::e_op_none;
    end
    if (issue_i) begin
      sb_n[issue_rd_i] = issue_kind_i;
    end
    sb_n[0] = pipe_pkg::e_op_none; // x0 never pending
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      for (int i = 0; i < `BP_REG_ELS; i++) begin
        sb_r[i] <= pipe_pkg::e_op_none;
      end
    end else begin
      sb_r <= sb_n;
    end
  end

  function automatic pipe_pkg::long_op_e owner_of(
    input logic               en,
    input pipe_pkg::long_op_e kind
  );
    return en ? kind : pipe_pkg::e_op_none;
  endfunction

  // operand lookups, gated by decode
  assign sb.rs1_kind = owner_of(sb.id_instr.read_rs1, sb_r[sb.id_instr.rs1]);
  assign sb.rs2_kind = owner_of(sb.id_instr.read_rs2, sb_r[sb.id_instr.rs2]);
  assign sb.rd_kind  = owner_of(sb.id_instr.write_rd, sb_r[sb.id_instr.rd]);

endmodule

`default_nettype wire

/* run.sh */
#!/bin/sh
# build with verilator, run, then judge the run by its log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log build.log
verilator --binary --timing --assert -Wno-fatal -f files.f \
  --top-module bubble_profiler_tb -o bubble_profiler_sim > build.log 2>&1 &&
  ./obj_dir/bubble_profiler_sim > sim.log 2>&1 ||
  echo "build or simulation ended with an error, see build.log and sim.log"
grep -q "ALL CHECKS PASSED" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }

/* tests/bubble_profiler_sva.sv */
`default_nettype none
`include "bubble_consts.svh"

module bubble_profiler_sva (
  input wire                          clk_i,
  input wire                          reset_i,
  input wire                          stall_all_i,
  input wire bubble_pkg::exe_bubble_e bubble_type_i,
  input wire [`BP_PC_WIDTH-1:0]       bubble_pc_i,
  input wire                          resp_valid_i,
  input wire                          resp_ready_i,
  input wire [`BP_CNT_WIDTH-1:0]      resp_count_i
);
  timeunit 1ns;
  timeprecision 100ps;

  // whole pipeline frozen
  hold_on_stall: assert property (
    @(posedge clk_i) disable iff (reset_i)
      stall_all_i |=> $stable(bubble_type_i) && $stable(bubble_pc_i)
  ) else $error("bubble class or pc moved while stall_all_i was high");

  no_bubble_pc_zero: assert property (
    @(posedge clk_i) disable iff (reset_i)
      (bubble_type_i == bubble_pkg::e_exe_no_bubble) |-> (bubble_pc_i == '0)
  ) else $error("no_bubble class carries a nonzero pc");

  resp_hold: assert property (
    @(posedge clk_i) disable iff (reset_i)
      (resp_valid_i && !resp_ready_i) |=> resp_valid_i && $stable(resp_count_i)
  ) else $error("counter response changed under back-pressure");

endmodule

bind exe_bubble_classifier bubble_profiler_sva classifier_sva (
  .clk_i         (clk_i),
  .reset_i       (reset_i),
  .stall_all_i   (stall_all_i),
  .bubble_type_i (exe_bubble_type_o),
  .bubble_pc_i   (exe_bubble_pc_o),
  .resp_valid_i  (1'b0), // no readout port here
  .resp_ready_i  (1'b1),
  .resp_count_i  ('0)
);

bind bubble_counter_bank bubble_profiler_sva counter_sva (
  .clk_i         (clk_i),
  .reset_i       (reset_i),
  .stall_all_i   (stall_all_i),
  .bubble_type_i (bubble_i),
  .bubble_pc_i   ('0), // bank sees the class only
  .resp_valid_i  (cnt_resp_valid_o),
  .resp_ready_i  (cnt_resp_ready_i),
  .resp_count_i  (cnt_resp_count_o)
);

`default_nettype wire

/* tests/bubble_profiler_tb.sv */
`default_nettype none
`include "bubble_consts.svh"

module bubble_profiler_tb;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int TIMEOUT_CYCLES = 400;

  logic clk_i = 1'b0;
  logic reset_i;
  logic issue_i, clear_i;
  pipe_pkg::long_op_e issue_kind_i;
  pipe_pkg::reg_addr_t issue_rd_i, clear_rd_i;
  logic [`BP_PC_WIDTH-1:0] if_pc_i, id_pc_i, exe_pc_i;
  pipe_pkg::id_instr_s id_instr_i;
  logic stall_all_i, icache_miss_i, icache_miss_in_pipe_i;
  logic branch_mispredict_i, jalr_mispredict_i, stall_depend_long_op_i;
  logic stall_depend_local_load_i, stall_depend_imul_i, stall_bypass_i;
  logic stall_remote_req_i, stall_remote_credit_i, stall_idiv_busy_i;
  bubble_pkg::exe_bubble_e exe_bubble_type_o;
  logic [`BP_PC_WIDTH-1:0] exe_bubble_pc_o;
  logic cnt_req_valid_i, cnt_req_ready_o, cnt_resp_valid_o, cnt_resp_ready_i;
  bubble_pkg::exe_bubble_e cnt_req_class_i;
  logic [`BP_CNT_WIDTH-1:0] cnt_resp_count_o;
  int cycles = 0;

  bubble_profiler_top DUT (.*);

  always #50 clk_i = ~clk_i;

  task automatic report_failure(input string msg);
    $display("%s", msg);
    $display("CHECKS FAILED");
    $fatal(1, "run stopped at first error");
  endtask

  always @(posedge clk_i) begin
    cycles++;
    if (cycles >= TIMEOUT_CYCLES) begin
      report_failure($sformatf("timeout: tests still running after %0d cycles", cycles));
    end
  end

  task automatic check_bubble(input bubble_pkg::exe_bubble_e exp);
    if (exe_bubble_type_o !== exp) begin
      report_failure($sformatf("FAILED at %0t: exe_bubble_type_o got %s expected %s",
                               $time, exe_bubble_type_o.name(), exp.name()));
    end
  endtask

  task automatic check_pc(input logic [`BP_PC_WIDTH-1:0] exp);
    if (exe_bubble_pc_o !== exp) begin
      report_failure($sformatf("FAILED at %0t: exe_bubble_pc_o got %h expected %h",
                               $time, exe_bubble_pc_o, exp));
    end
  endtask

  task automatic check_count(input logic [`BP_CNT_WIDTH-1:0] exp);
    if (cnt_resp_count_o !== exp) begin
      report_failure($sformatf("FAILED at %0t: cnt_resp_count_o got %0d expected %0d",
                               $time, cnt_resp_count_o, exp));
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      report_failure($sformatf("FAILED at %0t: %s got %b expected %b", $time, name, got, exp));
    end
  endtask

  function automatic logic [`BP_PC_WIDTH-1:0] rand_pc();
    return ($urandom & 32'hffff_fff0) | 32'h0000_1000; // never zero
  endfunction

  function automatic pipe_pkg::reg_addr_t rand_reg();
    return pipe_pkg::reg_addr_t'($urandom_range(31, 1));
  endfunction

  // bit 0 is the highest of the plain stall causes
  task automatic set_causes(input logic [5:0] v);
    stall_depend_local_load_i = v[0];
    stall_depend_imul_i       = v[1];
    stall_bypass_i            = v[2];
    stall_remote_req_i        = v[3];
    stall_remote_credit_i     = v[4];
    stall_idiv_busy_i         = v[5];
  endtask

  task automatic idle_inputs();
    issue_i = 1'b0;
    issue_kind_i = pipe_pkg::e_op_none;
    issue_rd_i = '0;
    clear_i = 1'b0;
    clear_rd_i = '0;
    if_pc_i = '0;
    id_pc_i = '0;
    exe_pc_i = '0;
    id_instr_i = '0;
    stall_all_i = 1'b0;
    icache_miss_i = 1'b0;
    icache_miss_in_pipe_i = 1'b0;
    branch_mispredict_i = 1'b0;
    jalr_mispredict_i = 1'b0;
    stall_depend_long_op_i = 1'b0;
    set_causes(6'h00);
    cnt_req_valid_i = 1'b0;
    cnt_req_class_i = bubble_pkg::e_exe_no_bubble;
    cnt_resp_ready_i = 1'b1;
  endtask

  task automatic reset_test();
    check_bubble(bubble_pkg::e_exe_no_bubble);
    check_pc('0);
    check_flag("cnt_req_ready_o", cnt_req_ready_o, 1'b1);
    check_flag("cnt_resp_valid_o", cnt_resp_valid_o, 1'b0);
  endtask

  task automatic mispredict_test(input logic jalr);
    logic [`BP_PC_WIDTH-1:0] pc;
    bubble_pkg::exe_bubble_e cls;
    pc = rand_pc();
    cls = jalr ? bubble_pkg::e_exe_jalr_miss : bubble_pkg::e_exe_branch_miss;
    exe_pc_i = pc;
    branch_mispredict_i = !jalr;
    jalr_mispredict_i = jalr;
    @(negedge clk_i);
    branch_mispredict_i = 1'b0;
    jalr_mispredict_i = 1'b0;
    exe_pc_i = pc + 32'd4;
    repeat (2) begin
      check_bubble(cls);
      check_pc(pc);
      @(negedge clk_i);
    end
    check_bubble(bubble_pkg::e_exe_no_bubble);
    check_pc('0);
  endtask

  task automatic icache_test();
    logic [`BP_PC_WIDTH-1:0] pc;
    pc = rand_pc();
    if_pc_i = pc;
    icache_miss_i = 1'b1;
    @(negedge clk_i);
    icache_miss_i = 1'b0;
    if_pc_i = pc + 32'd4;
    icache_miss_in_pipe_i = 1'b1;
    @(negedge clk_i);
    icache_miss_in_pipe_i = 1'b0;
    check_bubble(bubble_pkg::e_exe_no_bubble); // still in ID
    @(negedge clk_i);
    check_bubble(bubble_pkg::e_exe_icache_miss);
    check_pc(pc);
    @(negedge clk_i);
    check_bubble(bubble_pkg::e_exe_no_bubble);
  endtask

  task automatic dependency_test();
    pipe_pkg::reg_addr_t rd;
    logic [`BP_PC_WIDTH-1:0] pc;
    rd = rand_reg();
    pc = rand_pc();
    issue_i = 1'b1;
    issue_kind_i = pipe_pkg::e_op_dram_load;
    issue_rd_i = rd;
    @(negedge clk_i);
    issue_i = 1'b0;
    id_pc_i = pc;
    id_instr_i = '0;
    id_instr_i.rs1 = rd;
    id_instr_i.read_rs1 = 1'b1;
    stall_depend_long_op_i = 1'b1;
    set_causes(6'h01); // local_load ranks below the long-op dependency
    @(negedge clk_i);
    check_bubble(bubble_pkg::e_exe_depend_dram);
    check_pc(pc);
    set_causes(6'h00);
    clear_i = 1'b1;
    clear_rd_i = rd;
    @(negedge clk_i);
    clear_i = 1'b0;
    check_bubble(bubble_pkg::e_exe_depend_dram); // lookup saw the entry before the clear
    @(negedge clk_i);
    check_bubble(bubble_pkg::e_exe_no_bubble);
    check_pc('0);
    stall_depend_long_op_i = 1'b0;
    id_instr_i = '0;
  endtask

  task automatic priority_test();
    logic [`BP_PC_WIDTH-1:0] pc_id, pc_exe, pc_late;
    bubble_pkg::exe_bubble_e order [6];
    order = '{bubble_pkg::e_exe_depend_local_load, bubble_pkg::e_exe_depend_imul,
              bubble_pkg::e_exe_bypass, bubble_pkg::e_exe_remote_req,
              bubble_pkg::e_exe_remote_credit, bubble_pkg::e_exe_idiv_busy};
    pc_id = rand_pc();
    pc_exe = rand_pc();
    pc_late = rand_pc();
    id_pc_i = pc_id;
    exe_pc_i = pc_exe;
    set_causes(6'h3f);
    branch_mispredict_i = 1'b1;
    @(negedge clk_i);
    branch_mispredict_i = 1'b0;
    check_bubble(bubble_pkg::e_exe_branch_miss);
    check_pc(pc_exe);
    @(negedge clk_i);
    check_bubble(bubble_pkg::e_exe_branch_miss); // pending ID bubble outranks stalls
    check_pc(pc_exe);
    for (int i = 0; i < 6; i++) begin
      set_causes(6'(6'h3f << i));
      @(negedge clk_i);
      check_bubble(order[i]);
      check_pc(pc_id);
    end
    stall_all_i = 1'b1;
    set_causes(6'h01);
    id_pc_i = pc_late;
    repeat (3) begin
      @(negedge clk_i);
      check_bubble(bubble_pkg::e_exe_idiv_busy);
      check_pc(pc_id);
    end
    stall_all_i = 1'b0;
    @(negedge clk_i);
    check_bubble(bubble_pkg::e_exe_depend_local_load);
    check_pc(pc_late);
    set_causes(6'h00);
    @(negedge clk_i);
    check_bubble(bubble_pkg::e_exe_no_bubble);
    check_pc('0);
  endtask

  // depend_group shows up in no earlier test, so its counter starts at zero
  task automatic counter_test();
    pipe_pkg::reg_addr_t rd;
    int n;
    int tally;
    int expected;
    rd = rand_reg();
    n = $urandom_range(12, 5);
    tally = 0;
    issue_i = 1'b1;
    issue_kind_i = pipe_pkg::e_op_group_load;
    issue_rd_i = rd;
    @(negedge clk_i);
    issue_i = 1'b0;
    id_instr_i = '0;
    id_instr_i.rs2 = rd;
    id_instr_i.read_rs2 = 1'b1;
    id_pc_i = rand_pc();
    stall_depend_long_op_i = 1'b1;
    for (int k = 0; k < n; k++) begin
      @(negedge clk_i);
      check_bubble(bubble_pkg::e_exe_depend_group);
      tally++;
    end
    check_flag("cnt_req_ready_o", cnt_req_ready_o, 1'b1);
    cnt_req_valid_i = 1'b1;
    cnt_req_class_i = bubble_pkg::e_exe_depend_group;
    cnt_resp_ready_i = 1'b0;
    expected = tally - 1; // current cycle lands at the request edge itself
    repeat (4) begin
      @(negedge clk_i);
      cnt_req_valid_i = 1'b0;
      check_bubble(bubble_pkg::e_exe_depend_group); // still counting behind the response
      tally++;
      check_flag("cnt_resp_valid_o", cnt_resp_valid_o, 1'b1);
      check_flag("cnt_req_ready_o", cnt_req_ready_o, 1'b0);
      check_count(`BP_CNT_WIDTH'(expected));
    end
    stall_depend_long_op_i = 1'b0;
    id_instr_i = '0;
    cnt_resp_ready_i = 1'b1;
    @(negedge clk_i);
    check_flag("cnt_resp_valid_o", cnt_resp_valid_o, 1'b0);
    check_bubble(bubble_pkg::e_exe_no_bubble);
    cnt_req_valid_i = 1'b1;
    @(negedge clk_i);
    cnt_req_valid_i = 1'b0;
    check_flag("cnt_resp_valid_o", cnt_resp_valid_o, 1'b1);
    check_count(`BP_CNT_WIDTH'(tally));
    @(negedge clk_i);
    check_flag("cnt_resp_valid_o", cnt_resp_valid_o, 1'b0);
  endtask

  initial begin
    void'($urandom(32'ha2e5_ce08));
    idle_inputs();
    reset_i = 1'b1;
    repeat (2) @(negedge clk_i);
    reset_i = 1'b0;
    reset_test();
    mispredict_test(1'b0);
    mispredict_test(1'b1);
    icache_test();
    dependency_test();
    priority_test();
    counter_test();
    $display("ALL CHECKS PASSED");
    $finish;
  end

endmodule

`default_nettype wire
